// File: common/dphyPkg.sv
`default_nettype none

package dphyPkg;

    // levels driven on the Dp/Dn pair
    typedef enum logic [2:0] {
        LineOff,
        Lp00,
        Lp01,
        Lp10,
        Lp11,
        Hs0,
        Hs1
    } lineState;

    // lane controller states
    typedef enum logic [3:0] {
        Off,
        Init,
        Stop,
        HsStart,
        HsSync,
        HsData,
        HsTrail,
        HsExit,
        EscEntry,
        EscCmd,
        Ulps,
        UlpsWake,
        UlpsLeave
    } laneState;

    localparam int hsWordWidth = 8;

    // sent LSB first so the line reads 00011101
    localparam logic [hsWordWidth-1:0] hsSyncByte = 8'hB8;

    // ULPS entry command sent LSB first as well
    localparam logic [7:0] ulpsCmdByte = 8'h78;
    localparam int escCmdBits = $bits(ulpsCmdByte);

    // escape entry levels LP10 LP00 LP01 LP00 with one escape tick each
    localparam int escEntrySteps = 4;
    localparam lineState escEntryLevels [escEntrySteps] = '{Lp10, Lp00, Lp01, Lp00};

endpackage

`default_nettype wire

// File: hw/hsTx/hsSerializer.sv
`default_nettype none

module hsSerializer (
    input wire logic ppi,
    input wire logic hs_clk,
    input wire dphyPkg::laneState state,
    input wire logic txRequestHS,
    input wire logic [dphyPkg::hsWordWidth-1:0] txDataHS,
    output logic hsBit,
    output logic wordEnd,
    output logic txReadyHS
);
    import dphyPkg::*;

    localparam int cntWidth = $clog2(hsWordWidth);

    logic burst;
    logic [cntWidth-1:0] bitCnt;
    logic [hsWordWidth-1:0] shiftReg;

    assign burst = (state == HsSync) || (state == HsData);
    assign wordEnd = burst && (bitCnt == cntWidth'(hsWordWidth - 1));

    // the word is taken in the same cycle the ready pulse is seen
    assign txReadyHS = wordEnd && txRequestHS;
    assign hsBit = shiftReg[0];

    always_ff @(posedge ppi or negedge hs_clk)
    begin
        if (!hs_clk)
        begin
            bitCnt <= '0;
        end
        else if (!burst || wordEnd)
        begin
            bitCnt <= '0;
        end
        else
        begin
            bitCnt <= bitCnt + 1'b1;
        end
    end

    // sync byte is preloaded outside a burst so it is ready on the first HsSync cycle
    always_ff @(posedge ppi)
    begin
        if (!burst)
        begin
            shiftReg <= hsSyncByte;
        end
        else if (txReadyHS)
        begin
            shiftReg <= txDataHS;
        end
        else
        begin
            shiftReg <= shiftReg >> 1;
        end
    end

endmodule

`default_nettype wire

// File: hw/esc/escEncoder.sv
`default_nettype none

module escEncoder #(
    parameter int escDiv = 8
) (
    input wire logic ppi,
    input wire logic hs_clk,
    input wire logic escStart,
    output dphyPkg::lineState escLine,
    output logic escDone
);
    import dphyPkg::*;

    // entry levels followed by a mark tick and an LP00 tick per command bit
    localparam int totalSteps = escEntrySteps + 2 * escCmdBits;
    localparam int stepWidth = $clog2(totalSteps);
    localparam int divWidth = $clog2(escDiv + 1);
    localparam int entryIdxWidth = $clog2(escEntrySteps);

    logic active;
    logic [divWidth-1:0] divCnt;
    logic [stepWidth-1:0] stepCnt;
    logic [stepWidth-1:0] cmdStep;
    logic [escCmdBits-1:0] cmdShift;
    logic tick;
    logic lastStep;
    logic inCmd;

    assign tick = active && (divCnt == divWidth'(escDiv - 1));
    assign lastStep = (stepCnt == stepWidth'(totalSteps - 1));
    assign inCmd = (stepCnt >= stepWidth'(escEntrySteps));
    assign cmdStep = stepCnt - stepWidth'(escEntrySteps);
    assign escDone = tick && lastStep;

    always_ff @(posedge ppi or negedge hs_clk)
    begin
        if (!hs_clk)
        begin
            active <= 1'b0;
            divCnt <= '0;
            stepCnt <= '0;
        end
        else if (escStart)
        begin
            active <= 1'b1;
            divCnt <= '0;
            stepCnt <= '0;
        end
        else if (tick)
        begin
            divCnt <= '0;
            if (lastStep)
            begin
                active <= 1'b0;
            end
            else
            begin
                stepCnt <= stepCnt + 1'b1;
            end
        end
        else if (active)
        begin
            divCnt <= divCnt + 1'b1;
        end
    end

    // next bit comes forward at the end of each LP00 spacer
    always_ff @(posedge ppi)
    begin
        if (escStart)
        begin
            cmdShift <= ulpsCmdByte;
        end
        else if (tick && inCmd && cmdStep[0])
        begin
            cmdShift <= cmdShift >> 1;
        end
    end

    always_comb
    begin
        if (!active)
        begin
            escLine = Lp11;
        end
        else if (!inCmd)
        begin
            escLine = escEntryLevels[stepCnt[entryIdxWidth-1:0]];
        end
        else if (!cmdStep[0])
        begin
            // spaced one-hot where LP10 marks a one and LP01 a zero
            escLine = cmdShift[0] ? Lp10 : Lp01;
        end
        else
        begin
            escLine = Lp00;
        end
    end

endmodule

`default_nettype wire

// File: hw/laneCtrl/laneCtrl.sv
`default_nettype none

module laneCtrl #(
    parameter int tInit = 100,
    parameter int tLpx = 5,
    parameter int tHsPrepare = 6,
    parameter int tHsZero = 12,
    parameter int tHsTrail = 8,
    parameter int tHsExit = 10,
    parameter int tWakeup = 1000,
    parameter int escDiv = 8
) (
    input wire logic ppi,
    input wire logic hs_clk,
    input wire logic enable,
    input wire logic txRequestHS,
    input wire logic txRequestEsc,
    input wire logic txUlpsEsc,
    input wire logic txUlpsExit,
    input wire logic hsBit,
    input wire logic wordEnd,
    input wire dphyPkg::lineState escLine,
    input wire logic escDone,
    output dphyPkg::laneState state,
    output logic escStart,
    output logic stopstate,
    output logic ulpsActiveNot,
    output dphyPkg::lineState line
);
    import dphyPkg::*;

    // wide enough for the longest single phase
    localparam int timerWidth = $clog2(tInit + tLpx + tHsPrepare + tHsZero + tHsTrail
        + tHsExit + tWakeup + escEntrySteps * escDiv + 1);

    laneState nextState;
    logic timerLoad;
    logic [timerWidth-1:0] timerLoadVal;
    logic [timerWidth-1:0] timer;
    logic timerDone;
    logic lastBit;

    assign timerDone = (timer == '0);

    // phases of length N load N-1 and end when the timer reaches zero
    always_comb
    begin
        nextState = state;
        timerLoad = 1'b0;
        timerLoadVal = '0;
        case (state)
            Off:
            begin
                if (enable)
                begin
                    nextState = Init;
                    timerLoad = 1'b1;
                    timerLoadVal = timerWidth'(tInit - 1);
                end
            end
            Init, HsStart:
            begin
                if (timerDone)
                begin
                    nextState = (state == Init) ? Stop : HsSync;
                end
            end
            Stop:
            begin
                // HS wins if both requests come together
                if (txRequestHS)
                begin
                    nextState = HsStart;
                    timerLoad = 1'b1;
                    timerLoadVal = timerWidth'(tLpx + tHsPrepare + tHsZero - 1);
                end
                else if (txRequestEsc && txUlpsEsc)
                begin
                    nextState = EscEntry;
                    timerLoad = 1'b1;
                    timerLoadVal = timerWidth'(escEntrySteps * escDiv - 1);
                end
            end
            HsSync, HsData:
            begin
                if (wordEnd && !txRequestHS)
                begin
                    nextState = HsTrail;
                    timerLoad = 1'b1;
                    timerLoadVal = timerWidth'(tHsTrail - 1);
                end
                else if (wordEnd)
                begin
                    nextState = HsData;
                end
            end
            HsTrail:
            begin
                if (timerDone)
                begin
                    nextState = HsExit;
                    timerLoad = 1'b1;
                    timerLoadVal = timerWidth'(tHsExit - 1);
                end
            end
            HsExit:
            begin
                if (timerDone)
                begin
                    nextState = Stop;
                end
            end
            EscEntry:
            begin
                // runs in step with the entry levels of the escape encoder
                if (timerDone)
                begin
                    nextState = EscCmd;
                end
            end
            EscCmd:
            begin
                if (escDone)
                begin
                    nextState = Ulps;
                end
            end
            Ulps:
            begin
                if (txUlpsExit)
                begin
                    nextState = UlpsWake;
                    timerLoad = 1'b1;
                    timerLoadVal = timerWidth'(tWakeup - 1);
                end
            end
            UlpsWake:
            begin
                if (timerDone)
                begin
                    nextState = UlpsLeave;
                end
            end
            UlpsLeave:
            begin
                if (!txRequestEsc)
                begin
                    nextState = Stop;
                end
            end
            default:
            begin
                nextState = Off;
            end
        endcase
        // shutdown overrides everything
        if (!enable)
        begin
            nextState = Off;
        end
    end

    always_ff @(posedge ppi or negedge hs_clk)
    begin
        if (!hs_clk)
        begin
            state <= Off;
            timer <= '0;
        end
        else
        begin
            state <= nextState;
            if (timerLoad)
            begin
                timer <= timerLoadVal;
            end
            else if (!timerDone)
            begin
                timer <= timer - 1'b1;
            end
        end
    end

    // last bit on the line whose inverse forms the trail
    always_ff @(posedge ppi)
    begin
        if (state == HsSync || state == HsData)
        begin
            lastBit <= hsBit;
        end
    end

    always_comb
    begin
        case (state)
            Off: line = LineOff;
            Init, Stop, HsExit: line = Lp11;
            HsStart:
            begin
                // LP01 then LP00 then HS0 as the timer counts down
                if (timer >= timerWidth'(tHsPrepare + tHsZero))
                begin
                    line = Lp01;
                end
                else if (timer >= timerWidth'(tHsZero))
                begin
                    line = Lp00;
                end
                else
                begin
                    line = Hs0;
                end
            end
            HsSync, HsData: line = hsBit ? Hs1 : Hs0;
            HsTrail: line = lastBit ? Hs0 : Hs1;
            EscEntry, EscCmd: line = escLine;
            Ulps: line = Lp00;
            UlpsWake, UlpsLeave: line = Lp10;
            default: line = LineOff;
        endcase
    end

    assign escStart = (state == Stop) && (nextState == EscEntry);
    assign stopstate = (state == Stop);
    assign ulpsActiveNot = !(state == Ulps || state == UlpsWake);

endmodule

`default_nettype wire

// File: hw/dphyDataLane.sv
`default_nettype none

module dphyDataLane #(
    parameter int tInit = 100,
    parameter int tLpx = 5,
    parameter int tHsPrepare = 6,
    parameter int tHsZero = 12,
    parameter int tHsTrail = 8,
    parameter int tHsExit = 10,
    parameter int tWakeup = 1000,
    parameter int escDiv = 8
) (
    input wire logic ppi,
    input wire logic hs_clk,
    input wire logic enable,
    input wire logic txRequestHS,
    input wire logic [dphyPkg::hsWordWidth-1:0] txDataHS,
    input wire logic txRequestEsc,
    input wire logic txUlpsEsc,
    input wire logic txUlpsExit,
    output wire logic stopstate,
    output wire logic txReadyHS,
    output wire logic ulpsActiveNot,
    output wire dphyPkg::lineState line
);
    import dphyPkg::*;

    laneState state;
    logic hsBit;
    logic wordEnd;
    logic escStart;
    lineState escLine;
    logic escDone;

    laneCtrl #(
        .tInit(tInit),
        .tLpx(tLpx),
        .tHsPrepare(tHsPrepare),
        .tHsZero(tHsZero),
        .tHsTrail(tHsTrail),
        .tHsExit(tHsExit),
        .tWakeup(tWakeup),
        .escDiv(escDiv)
    ) laneCtrl0 (
        .ppi(ppi),
        .hs_clk(hs_clk),
        .enable(enable),
        .txRequestHS(txRequestHS),
        .txRequestEsc(txRequestEsc),
        .txUlpsEsc(txUlpsEsc),
        .txUlpsExit(txUlpsExit),
        .hsBit(hsBit),
        .wordEnd(wordEnd),
        .escLine(escLine),
        .escDone(escDone),
        .state(state),
        .escStart(escStart),
        .stopstate(stopstate),
        .ulpsActiveNot(ulpsActiveNot),
        .line(line)
    );

    hsSerializer hsSerializer0 (
        .ppi(ppi),
        .hs_clk(hs_clk),
        .state(state),
        .txRequestHS(txRequestHS),
        .txDataHS(txDataHS),
        .hsBit(hsBit),
        .wordEnd(wordEnd),
        .txReadyHS(txReadyHS)
    );

    escEncoder #(
        .escDiv(escDiv)
    ) escEncoder0 (
        .ppi(ppi),
        .hs_clk(hs_clk),
        .escStart(escStart),
        .escLine(escLine),
        .escDone(escDone)
    );

endmodule

`default_nettype wire

// File: test/laneMonitor.sv
`default_nettype none

module laneMonitor (
    input wire logic ppi,
    input wire dphyPkg::lineState line,
    output logic err,
    output logic errEsc,
    output logic errEmpty,
    output logic [7:0] errExp,
    output logic [7:0] errGot,
    output int hsBytes,
    output int syncSeen,
    output int escBytes
);
    timeunit 1ns;
    timeprecision 1ps;
    import dphyPkg::*;

    localparam logic [7:0] syncPattern = 8'hB8;
    localparam logic [7:0] ulpsCommand = 8'h78;

    logic [7:0] expQ[$];
    logic [7:0] window;
    logic synced;
    int bitIdx;
    lineState prevLine;
    lineState entryLevels [4];
    int entryIdx;
    int cmdBits;
    logic [7:0] cmdWord;

    initial
    begin
        err = 1'b0;
        errEsc = 1'b0;
        errEmpty = 1'b0;
        errExp = '0;
        errGot = '0;
        hsBytes = 0;
        syncSeen = 0;
        escBytes = 0;
        window = '0;
        synced = 1'b0;
        bitIdx = 0;
        prevLine = LineOff;
        entryLevels = '{Lp10, Lp00, Lp01, Lp00};
        entryIdx = 0;
        cmdBits = 0;
        cmdWord = '0;
    end

    task automatic expectByte(input logic [7:0] b);
        expQ.push_back(b);
    endtask

    task automatic checkHsByte(input logic [7:0] b);
        if (expQ.size() == 0)
        begin
            errEmpty = 1'b1;
            err = 1'b1;
        end
        else
        begin
            errExp = expQ.pop_front();
            errGot = b;
            if (errExp != b)
            begin
                err = 1'b1;
            end
            hsBytes++;
        end
    endtask

    always @(negedge ppi)
    begin
        // HS bits arrive LSB first so hunt for the sync pattern and then frame bytes
        if (line == Hs0 || line == Hs1)
        begin
            window = {line == Hs1, window[7:1]};
            if (!synced)
            begin
                if (window == syncPattern)
                begin
                    synced = 1'b1;
                    bitIdx = 0;
                    syncSeen++;
                end
            end
            else
            begin
                bitIdx++;
                if (bitIdx == 8)
                begin
                    bitIdx = 0;
                    checkHsByte(window);
                end
            end
        end
        else
        begin
            synced = 1'b0;
            window = '0;
        end

        // escape decoding only looks at level changes
        if (line != prevLine)
        begin
            if (line == Lp11 || line == LineOff || line == Hs0 || line == Hs1)
            begin
                entryIdx = 0;
                cmdBits = 0;
            end
            else if (entryIdx < 4)
            begin
                entryIdx = (line == entryLevels[entryIdx]) ? entryIdx + 1 : 0;
            end
            else if (cmdBits < 8 && (line == Lp10 || line == Lp01))
            begin
                cmdWord = {line == Lp10, cmdWord[7:1]};
                cmdBits++;
                if (cmdBits == 8)
                begin
                    escBytes++;
                    errExp = ulpsCommand;
                    errGot = cmdWord;
                    if (cmdWord != ulpsCommand)
                    begin
                        errEsc = 1'b1;
                        err = 1'b1;
                    end
                end
            end
        end
        prevLine = line;
    end

endmodule

`default_nettype wire

// File: test/tbDphyDataLane.sv
`default_nettype none

module tbDphyDataLane;
    timeunit 1ns;
    timeprecision 1ps;
    import dphyPkg::*;

    localparam int tInit = 10;
    localparam int tLpx = 3;
    localparam int tHsPrepare = 2;
    localparam int tHsZero = 4;
    localparam int tHsTrail = 3;
    localparam int tHsExit = 4;
    localparam int tWakeup = 12;
    localparam int escDiv = 2;
    localparam int nWords = 4;

    // cycle budget of each test, used by the watchdog
    localparam int burstLen = tLpx + tHsPrepare + tHsZero + 8 * (nWords + 2) + tHsTrail
        + tHsExit + 4;
    localparam int escLimit = (4 + 2 * 8 + 2) * escDiv + 4;
    localparam int ulpsLen = escLimit + tWakeup + 16;
    localparam int totalCycles = 8 + 2 * (tInit + 4) + 2 * burstLen + ulpsLen;

    logic ppi;
    logic hs_clk;
    logic enable;
    logic txRequestHS;
    logic [7:0] txDataHS;
    logic txRequestEsc;
    logic txUlpsEsc;
    logic txUlpsExit;
    logic stopstate;
    logic txReadyHS;
    logic ulpsActiveNot;
    lineState line;
    logic monErr;
    logic monErrEsc;
    logic monErrEmpty;
    logic [7:0] monExp;
    logic [7:0] monGot;
    int hsBytes;
    int syncSeen;
    int escBytes;
    integer seed;

    dphyDataLane #(
        .tInit(tInit),
        .tLpx(tLpx),
        .tHsPrepare(tHsPrepare),
        .tHsZero(tHsZero),
        .tHsTrail(tHsTrail),
        .tHsExit(tHsExit),
        .tWakeup(tWakeup),
        .escDiv(escDiv)
    ) dut0 (
        .ppi(ppi),
        .hs_clk(hs_clk),
        .enable(enable),
        .txRequestHS(txRequestHS),
        .txDataHS(txDataHS),
        .txRequestEsc(txRequestEsc),
        .txUlpsEsc(txUlpsEsc),
        .txUlpsExit(txUlpsExit),
        .stopstate(stopstate),
        .txReadyHS(txReadyHS),
        .ulpsActiveNot(ulpsActiveNot),
        .line(line)
    );

    laneMonitor mon0 (
        .ppi(ppi),
        .line(line),
        .err(monErr),
        .errEsc(monErrEsc),
        .errEmpty(monErrEmpty),
        .errExp(monExp),
        .errGot(monGot),
        .hsBytes(hsBytes),
        .syncSeen(syncSeen),
        .escBytes(escBytes)
    );

    initial
    begin
        ppi = 1'b0;
    end

    always #10 ppi = ~ppi;

    task automatic failValue(input string name, input logic [31:0] expv, input logic [31:0] gotv);
        $display("[FAIL] %s expected=%h got=%h", name, expv, gotv);
        $display("Simulation FAILED");
        $fatal(1);
    endtask

    task automatic failText(input string msg);
        $display("%s", msg);
        $display("Simulation FAILED");
        $fatal(1);
    endtask

    always @(posedge ppi)
    begin
        if (monErrEmpty)
        begin
            failText("HS byte decoded from the line with no word expected");
        end
        assert (!monErr) else failValue(monErrEsc ? "escape byte" : "hs byte", monExp, monGot);
    end

    task automatic checkLine(input lineState expLevel, input int cycles);
        repeat (cycles)
        begin
            @(negedge ppi);
            assert (line == expLevel) else failValue("line", expLevel, line);
        end
    endtask

    // idle outputs during reset and shutdown
    task automatic checkIdle();
        assert (line == LineOff) else failValue("line", LineOff, line);
        assert (!stopstate) else failValue("stopstate", 0, stopstate);
        assert (!txReadyHS) else failValue("txReadyHS", 0, txReadyHS);
        assert (ulpsActiveNot) else failValue("ulpsActiveNot", 1, ulpsActiveNot);
    endtask

    task automatic enableAndInit();
        @(posedge ppi);
        enable <= 1'b1;
        @(negedge ppi);
        checkIdle();
        repeat (tInit)
        begin
            @(negedge ppi);
            assert (line == Lp11) else failValue("line", Lp11, line);
            assert (!stopstate) else failValue("stopstate", 0, stopstate);
        end
        @(negedge ppi);
        assert (stopstate) else failValue("stopstate", 1, stopstate);
    endtask

    task automatic hsStart();
        @(posedge ppi);
        txRequestHS <= 1'b1;
        txDataHS <= 8'($random(seed));
        @(negedge ppi);
        assert (stopstate) else failText("lane was not in Stop when the burst was requested");
        checkLine(Lp01, tLpx);
        checkLine(Lp00, tHsPrepare);
        checkLine(Hs0, tHsZero);
    endtask

    task automatic hsBurst(input int words);
        int pulses;
        int waited;
        int bytesBefore;
        int syncBefore;
        logic [7:0] lastWord;
        lineState trailLevel;
        pulses = 0;
        waited = 0;
        bytesBefore = hsBytes;
        syncBefore = syncSeen;
        lastWord = '0;
        hsStart();
        while (pulses < words)
        begin
            @(negedge ppi);
            waited++;
            if (waited > 8 * (words + 2))
            begin
                failText("txReadyHS pulses stopped during the burst");
            end
            if (txReadyHS)
            begin
                // first pulse in the last sync cycle, then one per 8-cycle word
                assert (waited == 8 * (pulses + 1))
                    else failValue("txReadyHS cycle", 8 * (pulses + 1), waited);
                mon0.expectByte(txDataHS);
                lastWord = txDataHS;
                pulses++;
                @(posedge ppi);
                txDataHS <= 8'($random(seed));
                if (pulses == words)
                begin
                    txRequestHS <= 1'b0;
                end
            end
        end
        // last word goes out, then the trail inverts its final bit
        repeat (8) @(negedge ppi);
        if (lastWord[7])
        begin
            trailLevel = Hs0;
        end
        else
        begin
            trailLevel = Hs1;
        end
        checkLine(trailLevel, tHsTrail);
        checkLine(Lp11, tHsExit);
        @(negedge ppi);
        assert (stopstate) else failValue("stopstate", 1, stopstate);
        assert (syncSeen == syncBefore + 1) else failValue("syncSeen", syncBefore + 1, syncSeen);
        assert (hsBytes == bytesBefore + words) else failValue("hsBytes", bytesBefore + words,
            hsBytes);
    endtask

    task automatic ulpsCycle();
        int n;
        int wake;
        n = 0;
        wake = 0;
        @(posedge ppi);
        txRequestEsc <= 1'b1;
        txUlpsEsc <= 1'b1;
        @(negedge ppi);
        while (ulpsActiveNot && n < escLimit)
        begin
            @(negedge ppi);
            n++;
        end
        if (ulpsActiveNot)
        begin
            failText("ULPS entry was never acknowledged on ulpsActiveNot");
        end
        assert (escBytes == 1) else failValue("escBytes", 1, escBytes);
        checkLine(Lp00, 6);
        @(posedge ppi);
        txUlpsExit <= 1'b1;
        @(negedge ppi);
        @(negedge ppi);
        while (!ulpsActiveNot && wake < tWakeup + 5)
        begin
            assert (line == Lp10) else failValue("line", Lp10, line);
            wake++;
            @(negedge ppi);
        end
        assert (ulpsActiveNot) else failText("ulpsActiveNot stayed low after wake-up");
        assert (wake >= tWakeup) else failValue("wakeup cycles", tWakeup, wake);
        assert (line == Lp10) else failValue("line", Lp10, line);
        @(posedge ppi);
        txRequestEsc <= 1'b0;
        txUlpsEsc <= 1'b0;
        txUlpsExit <= 1'b0;
        @(negedge ppi);
        @(negedge ppi);
        assert (line == Lp11) else failValue("line", Lp11, line);
        assert (stopstate) else failValue("stopstate", 1, stopstate);
    endtask

    task automatic shutdownMidBurst();
        int n;
        n = 0;
        hsStart();
        while (!txReadyHS && n < 12)
        begin
            @(negedge ppi);
            n++;
        end
        if (!txReadyHS)
        begin
            failText("no txReadyHS pulse before the shutdown point");
        end
        @(posedge ppi);
        enable <= 1'b0;
        txRequestHS <= 1'b0;
        @(negedge ppi);
        @(negedge ppi);
        checkIdle();
    endtask

    initial
    begin
        seed = 99765;
        hs_clk = 1'b0;
        enable = 1'b0;
        txRequestHS = 1'b0;
        txDataHS = '0;
        txRequestEsc = 1'b0;
        txUlpsEsc = 1'b0;
        txUlpsExit = 1'b0;
        repeat (5)
        begin
            @(negedge ppi);
            checkIdle();
        end
        @(posedge ppi);
        hs_clk <= 1'b1;
        repeat (2) @(negedge ppi);
        checkIdle();
        enableAndInit();
        hsBurst(nWords);
        ulpsCycle();
        shutdownMidBurst();
        enableAndInit();
        hsBurst(1);
        @(negedge ppi);
        if (monErr || mon0.expQ.size() != 0)
        begin
            $display("expected HS words were left unchecked by the lane monitor");
            $display("Simulation FAILED");
            $fatal(1);
        end
        else
        begin
            $display("Simulation PASSED");
            $finish;
        end
    end

    initial
    begin
        repeat (totalCycles * 3 / 2) @(posedge ppi);
        $display("watchdog expired before the test sequence finished");
        $display("Simulation FAILED");
        $fatal(1);
    end

endmodule

`default_nettype wire

// File: list.f
common/dphyPkg.sv
hw/hsTx/hsSerializer.sv
hw/esc/escEncoder.sv
hw/laneCtrl/laneCtrl.sv
hw/dphyDataLane.sv
test/laneMonitor.sv
test/tbDphyDataLane.sv
